// ==== hdl/serv_isa_pkg.sv ====
package serv_isa_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [31:0]     instr_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [2:0]      funct3_t;
   typedef logic [6:0]      opcode_t;

   // Major opcodes
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;

   // funct3 values shared by OP and OP-IMM
   localparam funct3_t F3_ADD = 3'b000;
   localparam funct3_t F3_XOR = 3'b100;
   localparam funct3_t F3_OR  = 3'b110;
   localparam funct3_t F3_AND = 3'b111;

   // funct7 values differ only in bit 30
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// ==== hdl/serv_core_pkg.sv ====
package serv_core_pkg;

   typedef logic [4:0] cnt_t;

   localparam cnt_t CNT_LAST = 5'd31;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // 32 bit cycles then one retire cycle per instruction
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_RETIRE
   } state_e;

endpackage

// ==== hdl/serv_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_state (
   input  logic                clk,
   input  logic                i_reset,
   input  logic                i_instr_valid,
   output logic                o_busy,
   output serv_core_pkg::cnt_t o_cnt,
   output logic                o_cnt_en,
   output logic                o_cnt_first,
   output logic                o_cnt_done,
   output logic                o_retire);

   serv_core_pkg::state_e state;

   assign o_busy      = (state != serv_core_pkg::ST_IDLE);
   assign o_cnt_en    = (state == serv_core_pkg::ST_RUN);
   assign o_cnt_first = o_cnt_en && (o_cnt == '0);
   assign o_cnt_done  = o_cnt_en && (o_cnt == serv_core_pkg::CNT_LAST);
   assign o_retire    = (state == serv_core_pkg::ST_RETIRE);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= serv_core_pkg::ST_IDLE;
         o_cnt <= '0;
      end else begin
         case (state)
            serv_core_pkg::ST_IDLE: begin
               if (i_instr_valid) begin
                  state <= serv_core_pkg::ST_RUN;
                  o_cnt <= '0;
               end
            end
            serv_core_pkg::ST_RUN: begin
               // Counter wraps back to zero on the last bit
               o_cnt <= o_cnt + 1'b1;
               if (o_cnt_done)
                  state <= serv_core_pkg::ST_RETIRE;
            end
            default: state <= serv_core_pkg::ST_IDLE;
         endcase
      end
   end

   a_no_strobe_busy: assert property (@(posedge clk) disable iff (i_reset)
      i_instr_valid |-> !o_busy)
      else $error("Instruction strobe while core busy");

   a_run_ends: assert property (@(posedge clk) disable iff (i_reset)
      o_retire |-> o_cnt == '0)
      else $error("Bit counter ran past the last bit");

endmodule
`default_nettype wire

// ==== hdl/serv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_decode (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_instr_valid,
   input  serv_isa_pkg::instr_t     i_instr,
   output serv_isa_pkg::reg_addr_t  o_rs1_addr,
   output serv_isa_pkg::reg_addr_t  o_rs2_addr,
   output serv_isa_pkg::reg_addr_t  o_rd_addr,
   output serv_core_pkg::alu_op_e   o_alu_op,
   output logic                     o_imm_sel,
   output logic                     o_rd_wen,
   output logic                     o_illegal);

   serv_isa_pkg::opcode_t  opcode;
   serv_isa_pkg::funct3_t  funct3;
   logic [6:0]             funct7;
   logic                   f3_ok;
   logic                   legal;
   serv_core_pkg::alu_op_e alu_op;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   always_comb begin
      f3_ok  = 1'b1;
      alu_op = serv_core_pkg::ALU_ADD;
      case (funct3)
         serv_isa_pkg::F3_ADD: alu_op = serv_core_pkg::ALU_ADD;
         serv_isa_pkg::F3_XOR: alu_op = serv_core_pkg::ALU_XOR;
         serv_isa_pkg::F3_OR:  alu_op = serv_core_pkg::ALU_OR;
         serv_isa_pkg::F3_AND: alu_op = serv_core_pkg::ALU_AND;
         default:              f3_ok  = 1'b0;
      endcase

      legal = 1'b0;
      if (opcode == serv_isa_pkg::OPC_OP_IMM) begin
         legal = f3_ok;
      end else if (opcode == serv_isa_pkg::OPC_OP) begin
         if (funct7 == serv_isa_pkg::F7_BASE) begin
            legal = f3_ok;
         end else if (funct7 == serv_isa_pkg::F7_SUB &&
                      funct3 == serv_isa_pkg::F3_ADD) begin
            legal  = 1'b1;
            alu_op = serv_core_pkg::ALU_SUB;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_rs1_addr <= '0;
         o_rs2_addr <= '0;
         o_rd_addr  <= '0;
         o_alu_op   <= serv_core_pkg::ALU_ADD;
         o_imm_sel  <= 1'b0;
         o_rd_wen   <= 1'b0;
         o_illegal  <= 1'b0;
      end else if (i_instr_valid) begin
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
         o_rd_addr  <= i_instr[11:7];
         o_alu_op   <= alu_op;
         o_imm_sel  <= (opcode == serv_isa_pkg::OPC_OP_IMM);
         o_rd_wen   <= legal && (i_instr[11:7] != '0);
         o_illegal  <= !legal;
      end
   end

   a_no_sub_imm: assert property (@(posedge clk) disable iff (i_reset)
      o_imm_sel |-> o_alu_op != serv_core_pkg::ALU_SUB)
      else $error("Subtract decoded for an immediate form");

endmodule
`default_nettype wire

// ==== hdl/serv_immdec.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_immdec (
   input  logic                 clk,
   input  logic                 i_instr_valid,
   input  serv_isa_pkg::instr_t i_instr,
   input  logic                 i_cnt_en,
   output logic                 o_imm_bit);

   logic [11:0] imm_q;

   // I-type immediate shifted out LSB first
   assign o_imm_bit = imm_q[0];

   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         imm_q <= i_instr[31:20];
      end else if (i_cnt_en) begin
         // Top bit stays put so the sign fills the upper 20 bits
         imm_q <= {imm_q[11], imm_q[11:1]};
      end
   end

endmodule
`default_nettype wire

// ==== hdl/serv_rf.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_rf (
   input  logic                    clk,
   input  logic                    i_reset,
   input  serv_core_pkg::cnt_t     i_cnt,
   input  logic                    i_cnt_en,
   input  serv_isa_pkg::reg_addr_t i_rs1_addr,
   input  serv_isa_pkg::reg_addr_t i_rs2_addr,
   input  serv_isa_pkg::reg_addr_t i_rd_addr,
   input  logic                    i_rd_wen,
   input  logic                    i_rd_bit,
   output logic                    o_rs1_bit,
   output logic                    o_rs2_bit);

   serv_isa_pkg::word_t regs [32];

   // Bit i is read before the write of bit i lands, so rd may equal rs
   assign o_rs1_bit = regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_cnt_en && i_rd_wen && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

endmodule
`default_nettype wire

// ==== hdl/serv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  logic                   clk,
   input  logic                   i_cnt_en,
   input  logic                   i_cnt_first,
   input  serv_core_pkg::alu_op_e i_alu_op,
   input  logic                   i_imm_sel,
   input  logic                   i_rs1_bit,
   input  logic                   i_rs2_bit,
   input  logic                   i_imm_bit,
   output logic                   o_rd_bit);

   logic sub;
   logic op_b;
   logic add_b;
   logic carry_in;
   logic carry_q;
   logic sum;

   assign sub   = (i_alu_op == serv_core_pkg::ALU_SUB);
   assign op_b  = i_imm_sel ? i_imm_bit : i_rs2_bit;
   assign add_b = op_b ^ sub;

   // Subtract is a + ~b with the +1 entering as the first carry
   assign carry_in = i_cnt_first ? sub : carry_q;
   assign sum      = i_rs1_bit ^ add_b ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_cnt_en)
         carry_q <= (i_rs1_bit & add_b) | (carry_in & (i_rs1_bit ^ add_b));
   end

   always_comb begin
      case (i_alu_op)
         serv_core_pkg::ALU_AND: o_rd_bit = i_rs1_bit & op_b;
         serv_core_pkg::ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
         serv_core_pkg::ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
         default:                o_rd_bit = sum;
      endcase
   end

endmodule
`default_nettype wire

// ==== hdl/serv_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_retire (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_cnt_en,
   input  logic                    i_rd_bit,
   input  logic                    i_retire,
   input  serv_isa_pkg::reg_addr_t i_rd_addr,
   input  logic                    i_illegal,
   output logic                    o_rd_valid,
   output serv_isa_pkg::reg_addr_t o_rd_addr,
   output serv_isa_pkg::word_t     o_rd_data,
   output logic                    o_illegal);

   serv_isa_pkg::word_t data_q;

   // LSB arrives first and ends up at bit 0 after 32 shifts
   always_ff @(posedge clk) begin
      if (i_reset)
         data_q <= '0;
      else if (i_cnt_en)
         data_q <= {i_rd_bit, data_q[serv_isa_pkg::XLEN-1:1]};
   end

   assign o_rd_valid = i_retire;
   assign o_rd_addr  = i_rd_addr;
   assign o_rd_data  = data_q;
   assign o_illegal  = i_retire & i_illegal;

endmodule
`default_nettype wire

// ==== hdl/serv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_top (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_instr_valid,
   input  serv_isa_pkg::instr_t    i_instr,
   output logic                    o_busy,
   output logic                    o_rd_valid,
   output serv_isa_pkg::reg_addr_t o_rd_addr,
   output serv_isa_pkg::word_t     o_rd_data,
   output logic                    o_illegal);

   serv_core_pkg::cnt_t     cnt;
   logic                    cnt_en;
   logic                    cnt_first;
   logic                    retire;
   serv_isa_pkg::reg_addr_t rs1_addr;
   serv_isa_pkg::reg_addr_t rs2_addr;
   serv_isa_pkg::reg_addr_t rd_addr;
   serv_core_pkg::alu_op_e  alu_op;
   logic                    imm_sel;
   logic                    rd_wen;
   logic                    illegal;
   logic                    rs1_bit;
   logic                    rs2_bit;
   logic                    imm_bit;
   logic                    rd_bit;

   serv_state state (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .o_busy        (o_busy),
      .o_cnt         (cnt),
      .o_cnt_en      (cnt_en),
      .o_cnt_first   (cnt_first),
      .o_cnt_done    (),
      .o_retire      (retire));

   serv_decode decode (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_alu_op      (alu_op),
      .o_imm_sel     (imm_sel),
      .o_rd_wen      (rd_wen),
      .o_illegal     (illegal));

   serv_immdec immdec (
      .clk           (clk),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_cnt_en      (cnt_en),
      .o_imm_bit     (imm_bit));

   serv_rf rf (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_wen   (rd_wen),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit));

   serv_alu alu (
      .clk         (clk),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .i_alu_op    (alu_op),
      .i_imm_sel   (imm_sel),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .i_imm_bit   (imm_bit),
      .o_rd_bit    (rd_bit));

   serv_retire retire_stage (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt_en   (cnt_en),
      .i_rd_bit   (rd_bit),
      .i_retire   (retire),
      .i_rd_addr  (rd_addr),
      .i_illegal  (illegal),
      .o_rd_valid (o_rd_valid),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data),
      .o_illegal  (o_illegal));

endmodule
`default_nettype wire

// ==== sim/serv_top_tb.sv ====
`timescale 1ns/1ps

module serv_top_tb;

   localparam int RETIRE_TIMEOUT = 40;
   localparam int IDLE_TIMEOUT   = 8;

   logic                    clk;
   logic                    i_reset;
   logic                    i_instr_valid;
   serv_isa_pkg::instr_t    i_instr;
   logic                    o_busy;
   logic                    o_rd_valid;
   serv_isa_pkg::reg_addr_t o_rd_addr;
   serv_isa_pkg::word_t     o_rd_data;
   logic                    o_illegal;

   serv_top UUT (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_busy        (o_busy),
      .o_rd_valid    (o_rd_valid),
      .o_rd_addr     (o_rd_addr),
      .o_rd_data     (o_rd_data),
      .o_illegal     (o_illegal));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_word(input string name, input serv_isa_pkg::word_t expected,
                             input serv_isa_pkg::word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_addr(input string name, input serv_isa_pkg::reg_addr_t expected,
                             input serv_isa_pkg::reg_addr_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // One-cycle strobe, starting and ending on a falling edge
   task automatic issue_instr(input serv_isa_pkg::instr_t word);
      i_instr       = word;
      i_instr_valid = 1'b1;
      @(negedge clk);
      i_instr_valid = 1'b0;
      i_instr       = '0;
   endtask

   task automatic wait_retire(input serv_isa_pkg::instr_t word);
      int cycles;
      cycles = 0;
      while (o_rd_valid !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (o_rd_valid !== 1'b1) begin
         $display("Instruction %h never retired within %0d cycles", word, RETIRE_TIMEOUT);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic wait_idle(input serv_isa_pkg::instr_t word);
      int cycles;
      cycles = 0;
      while (o_busy !== 1'b0 && cycles < IDLE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (o_busy !== 1'b0) begin
         $display("Core still busy %0d cycles after retiring %h", IDLE_TIMEOUT, word);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   initial begin
      int                      fd;
      int                      fields;
      int                      executed;
      logic                    at_end;
      logic [8*128-1:0]        line;
      serv_isa_pkg::instr_t    instr_word;
      serv_isa_pkg::reg_addr_t exp_rd;
      serv_isa_pkg::word_t     exp_data;
      logic                    exp_illegal;

      i_reset       = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      executed      = 0;
      at_end        = 1'b0;

      fd = $fopen("sim/serv_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the input file sim/serv_input.txt");
         $display("Simulation FAILED");
         $fatal(1);
      end

      repeat (2) @(negedge clk);
      i_reset = 1'b0;

      check_flag("o_busy", 1'b0, o_busy);
      check_flag("o_rd_valid", 1'b0, o_rd_valid);
      check_flag("o_illegal", 1'b0, o_illegal);

      while (!at_end) begin
         line = '0;
         if ($fgets(line, fd) == 0) begin
            at_end = 1'b1;
         end else begin
            // Comment and blank lines scan no fields
            fields = $sscanf(line, "%h %h %h %h", instr_word, exp_rd, exp_data, exp_illegal);
            if (fields == 4) begin
               issue_instr(instr_word);
               check_flag("o_busy", 1'b1, o_busy);
               wait_retire(instr_word);
               check_flag("o_busy", 1'b1, o_busy);
               check_addr("o_rd_addr", exp_rd, o_rd_addr);
               check_flag("o_illegal", exp_illegal, o_illegal);
               if (!exp_illegal)
                  check_word("o_rd_data", exp_data, o_rd_data);
               wait_idle(instr_word);
               // Retire strobe lasts one cycle
               check_flag("o_rd_valid", 1'b0, o_rd_valid);
               check_flag("o_illegal", 1'b0, o_illegal);
               executed++;
            end else if (fields > 0) begin
               $display("Malformed line in the input file after %0d instructions", executed);
               $display("Simulation FAILED");
               $fatal(1);
            end
         end
      end
      $fclose(fd);

      if (executed == 0) begin
         $display("The input file held no instructions");
         $display("Simulation FAILED");
         $fatal(1);
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

// ==== sim/serv_input.txt ====
# instruction  expected_rd  expected_result  expected_illegal   (all hex)
# result is ignored when the illegal flag is 1
00500093 01 00000005 0
fff00113 02 ffffffff 0
7f004193 03 000007f0 0
aaa04213 04 fffffaaa 0
ff808293 05 fffffffd 0
00208333 06 00000004 0
403083b3 07 fffff815 0
40118433 08 000007eb 0
0041f4b3 09 000002a0 0
0041e533 0a fffffffa 0
0042c5b3 0b 00000557 0
0f017613 0c 000000f0 0
80a0e693 0d fffff80f 0
12308013 00 00000128 0
00100733 0e 00000005 0
0000a303 06 00000000 1
00030793 0f 00000004 0
00309393 07 00000000 1
00038813 10 fffff815 0
4020e433 08 00000000 1
000408b3 11 000007eb 0
01188933 12 00000fd6 0
40e90933 12 00000fd1 0

// ==== build.f ====
hdl/serv_isa_pkg.sv
hdl/serv_core_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_immdec.sv
hdl/serv_rf.sv
hdl/serv_alu.sv
hdl/serv_retire.sv
hdl/serv_top.sv
sim/serv_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module serv_top_tb -f build.f -o serv_top_tb_sim

out=$(./obj_dir/serv_top_tb_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
   exit 0
else
   exit 1
fi
